//--- design/axi_xbar_pkg.sv
package axi_xbar_pkg;

    localparam int AXI_ADDR_BITS = 32;
    localparam int AXI_DATA_BITS = 32;
    localparam int AXI_ID_BITS   = 4;
    // Slave side carries the master index above the master ID
    localparam int AXI_IDS_BITS  = AXI_ID_BITS + 1;
    localparam int AXI_LEN_BITS  = 4;
    localparam int AXI_RESP_BITS = 2;

    typedef logic [AXI_ADDR_BITS-1:0] addr_t;
    typedef logic [AXI_DATA_BITS-1:0] data_t;
    typedef logic [AXI_ID_BITS-1:0]   id_t;
    typedef logic [AXI_IDS_BITS-1:0]  ids_t;
    typedef logic [AXI_LEN_BITS-1:0]  len_t;
    typedef logic [AXI_RESP_BITS-1:0] resp_t;
    typedef logic [1:0]               slave_sel_t;

    localparam slave_sel_t SLAVE0        = 2'd0;
    localparam slave_sel_t SLAVE1        = 2'd1;
    localparam slave_sel_t SLAVE_DEFAULT = 2'd2;

    // Address map, everything else goes to the default slave
    localparam addr_t S0_BASE    = 32'h0000_0000;
    localparam addr_t S1_BASE    = 32'h0001_0000;
    localparam addr_t SLAVE_SPAN = 32'h0001_0000;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

endpackage

//--- design/ar_addr_decode.sv
`timescale 1ns/1ps

module ar_addr_decode (
    input  logic                clk_i,
    input  logic                rst_i,
    input  axi_xbar_pkg::id_t   m0_ar_id_i,
    input  axi_xbar_pkg::addr_t m0_ar_addr_i,
    input  axi_xbar_pkg::len_t  m0_ar_len_i,
    input  logic                m0_ar_valid_i,
    output logic                m0_ar_ready_o,
    input  axi_xbar_pkg::id_t   m1_ar_id_i,
    input  axi_xbar_pkg::addr_t m1_ar_addr_i,
    input  axi_xbar_pkg::len_t  m1_ar_len_i,
    input  logic                m1_ar_valid_i,
    output logic                m1_ar_ready_o,
    output axi_xbar_pkg::ids_t  s0_ar_id_o,
    output axi_xbar_pkg::addr_t s0_ar_addr_o,
    output axi_xbar_pkg::len_t  s0_ar_len_o,
    output logic                s0_ar_valid_o,
    input  logic                s0_ar_ready_i,
    output axi_xbar_pkg::ids_t  s1_ar_id_o,
    output axi_xbar_pkg::addr_t s1_ar_addr_o,
    output axi_xbar_pkg::len_t  s1_ar_len_o,
    output logic                s1_ar_valid_o,
    input  logic                s1_ar_ready_i,
    output axi_xbar_pkg::ids_t  dflt_ar_id_o,
    output axi_xbar_pkg::addr_t dflt_ar_addr_o,
    output axi_xbar_pkg::len_t  dflt_ar_len_o,
    output logic                dflt_ar_valid_o,
    input  logic                dflt_ar_ready_i
);

    import axi_xbar_pkg::*;

    logic       held_q;
    logic       held_m_q;
    logic       sel_m;
    logic       req_valid;
    id_t        req_id;
    ids_t       req_ids;
    addr_t      req_addr;
    len_t       req_len;
    slave_sel_t target;
    logic       tgt_ready;

    // Held grant wins, otherwise master 0 first
    assign sel_m = held_q ? held_m_q : ~m0_ar_valid_i;

    always_comb begin
        if (sel_m) begin
            req_valid = m1_ar_valid_i;
            req_id    = m1_ar_id_i;
            req_addr  = m1_ar_addr_i;
            req_len   = m1_ar_len_i;
        end else begin
            req_valid = m0_ar_valid_i;
            req_id    = m0_ar_id_i;
            req_addr  = m0_ar_addr_i;
            req_len   = m0_ar_len_i;
        end
    end

    always_comb begin
        if (addr_t'(req_addr - S0_BASE) < SLAVE_SPAN)
            target = SLAVE0;
        else if (addr_t'(req_addr - S1_BASE) < SLAVE_SPAN)
            target = SLAVE1;
        else
            target = SLAVE_DEFAULT;
    end

    always_comb begin
        case (target)
            SLAVE0:  tgt_ready = s0_ar_ready_i;
            SLAVE1:  tgt_ready = s1_ar_ready_i;
            default: tgt_ready = dflt_ar_ready_i;
        endcase
    end

    assign req_ids = {sel_m, req_id};

    assign s0_ar_id_o      = req_ids;
    assign s0_ar_addr_o    = req_addr;
    assign s0_ar_len_o     = req_len;
    assign s0_ar_valid_o   = req_valid && (target == SLAVE0);
    assign s1_ar_id_o      = req_ids;
    assign s1_ar_addr_o    = req_addr;
    assign s1_ar_len_o     = req_len;
    assign s1_ar_valid_o   = req_valid && (target == SLAVE1);
    assign dflt_ar_id_o    = req_ids;
    assign dflt_ar_addr_o  = req_addr;
    assign dflt_ar_len_o   = req_len;
    assign dflt_ar_valid_o = req_valid && (target == SLAVE_DEFAULT);

    assign m0_ar_ready_o = ~sel_m & tgt_ready;
    assign m1_ar_ready_o = sel_m & tgt_ready;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            held_q   <= 1'b0;
            held_m_q <= 1'b0;
        end else begin
            held_q   <= req_valid && !tgt_ready;
            held_m_q <= sel_m;
        end
    end

    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0({s0_ar_valid_o, s1_ar_valid_o, dflt_ar_valid_o}));

    // A waiting request keeps its master, ID and address
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_valid && !tgt_ready |=> req_valid && $stable(req_ids) && $stable(req_addr));

endmodule

//--- design/default_slave.sv
`timescale 1ns/1ps

module default_slave (
    input  logic                clk_i,
    input  logic                rst_i,
    input  axi_xbar_pkg::ids_t  ar_id_i,
    input  axi_xbar_pkg::len_t  ar_len_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    output axi_xbar_pkg::ids_t  r_id_o,
    output axi_xbar_pkg::data_t r_data_o,
    output axi_xbar_pkg::resp_t r_resp_o,
    output logic                r_last_o,
    output logic                r_valid_o,
    input  logic                r_ready_i
);

    import axi_xbar_pkg::*;

    typedef enum logic {
        IDLE,
        BURST
    } state_t;

    state_t state_q;
    len_t   beats_q;
    ids_t   id_q;

    assign ar_ready_o = (state_q == IDLE);
    assign r_valid_o  = (state_q == BURST);
    assign r_id_o     = id_q;
    assign r_data_o   = '0;
    assign r_resp_o   = RESP_DECERR;
    // Counter holds beats still to go after the current one
    assign r_last_o   = (beats_q == '0);

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            beats_q <= '0;
        end else if (state_q == IDLE) begin
            if (ar_valid_i) begin
                state_q <= BURST;
                beats_q <= ar_len_i;
            end
        end else if (r_ready_i) begin
            if (r_last_o)
                state_q <= IDLE;
            else
                beats_q <= beats_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_valid_i && ar_ready_o)
            id_q <= ar_id_i;
    end

    a_beat_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_id_o) && $stable(r_last_o));

endmodule

//--- design/r_return_router.sv
`timescale 1ns/1ps

module r_return_router (
    input  logic                clk_i,
    input  logic                rst_i,
    input  axi_xbar_pkg::ids_t  src0_r_id_i,
    input  axi_xbar_pkg::data_t src0_r_data_i,
    input  axi_xbar_pkg::resp_t src0_r_resp_i,
    input  logic                src0_r_last_i,
    input  logic                src0_r_valid_i,
    output logic                src0_r_ready_o,
    input  axi_xbar_pkg::ids_t  src1_r_id_i,
    input  axi_xbar_pkg::data_t src1_r_data_i,
    input  axi_xbar_pkg::resp_t src1_r_resp_i,
    input  logic                src1_r_last_i,
    input  logic                src1_r_valid_i,
    output logic                src1_r_ready_o,
    input  axi_xbar_pkg::ids_t  srcd_r_id_i,
    input  axi_xbar_pkg::data_t srcd_r_data_i,
    input  axi_xbar_pkg::resp_t srcd_r_resp_i,
    input  logic                srcd_r_last_i,
    input  logic                srcd_r_valid_i,
    output logic                srcd_r_ready_o,
    output axi_xbar_pkg::id_t   m0_r_id_o,
    output axi_xbar_pkg::data_t m0_r_data_o,
    output axi_xbar_pkg::resp_t m0_r_resp_o,
    output logic                m0_r_last_o,
    output logic                m0_r_valid_o,
    input  logic                m0_r_ready_i,
    output axi_xbar_pkg::id_t   m1_r_id_o,
    output axi_xbar_pkg::data_t m1_r_data_o,
    output axi_xbar_pkg::resp_t m1_r_resp_o,
    output logic                m1_r_last_o,
    output logic                m1_r_valid_o,
    input  logic                m1_r_ready_i
);

    import axi_xbar_pkg::*;

    // One-hot per source: bit 0 slave 0, bit 1 slave 1, bit 2 default
    logic [2:0] lock_q;
    logic [2:0] grant;
    ids_t       ids_s;
    data_t      data_s;
    resp_t      resp_s;
    logic       last_s;
    logic       valid_s;
    logic       master;
    logic       ready_m;

    always_comb begin
        if (|lock_q)
            grant = lock_q;
        else if (srcd_r_valid_i)
            grant = 3'b100;
        else if (src1_r_valid_i)
            grant = 3'b010;
        else if (src0_r_valid_i)
            grant = 3'b001;
        else
            grant = 3'b000;
    end

    always_comb begin
        case (grant)
            3'b001:  {ids_s, data_s, resp_s, last_s, valid_s} = {src0_r_id_i, src0_r_data_i,
                         src0_r_resp_i, src0_r_last_i, src0_r_valid_i};
            3'b010:  {ids_s, data_s, resp_s, last_s, valid_s} = {src1_r_id_i, src1_r_data_i,
                         src1_r_resp_i, src1_r_last_i, src1_r_valid_i};
            3'b100:  {ids_s, data_s, resp_s, last_s, valid_s} = {srcd_r_id_i, srcd_r_data_i,
                         srcd_r_resp_i, srcd_r_last_i, srcd_r_valid_i};
            default: {ids_s, data_s, resp_s, last_s, valid_s} = '0;
        endcase
    end

    // Top ID bit names the master
    assign master  = ids_s[AXI_IDS_BITS-1];
    assign ready_m = master ? m1_r_ready_i : m0_r_ready_i;

    assign m0_r_id_o    = ids_s[AXI_ID_BITS-1:0];
    assign m0_r_data_o  = data_s;
    assign m0_r_resp_o  = resp_s;
    assign m0_r_last_o  = last_s;
    assign m0_r_valid_o = valid_s & ~master;
    assign m1_r_id_o    = ids_s[AXI_ID_BITS-1:0];
    assign m1_r_data_o  = data_s;
    assign m1_r_resp_o  = resp_s;
    assign m1_r_last_o  = last_s;
    assign m1_r_valid_o = valid_s & master;

    assign {srcd_r_ready_o, src1_r_ready_o, src0_r_ready_o} = grant & {3{ready_m}};

    // Lock on the first presented beat, release after the last is taken
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i)
            lock_q <= 3'b000;
        else if (valid_s && ready_m && last_s)
            lock_q <= 3'b000;
        else if (valid_s)
            lock_q <= grant;
    end

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0(grant));

    a_lock_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
        (|lock_q) && !(valid_s && ready_m && last_s) |=> $stable(lock_q));

endmodule

//--- design/axi_read_xbar.sv
`timescale 1ns/1ps

module axi_read_xbar (
    input  logic                clk,
    input  logic                rst,
    input  axi_xbar_pkg::id_t   m0_ar_id_i,
    input  axi_xbar_pkg::addr_t m0_ar_addr_i,
    input  axi_xbar_pkg::len_t  m0_ar_len_i,
    input  logic                m0_ar_valid_i,
    output logic                m0_ar_ready_o,
    output axi_xbar_pkg::id_t   m0_r_id_o,
    output axi_xbar_pkg::data_t m0_r_data_o,
    output axi_xbar_pkg::resp_t m0_r_resp_o,
    output logic                m0_r_last_o,
    output logic                m0_r_valid_o,
    input  logic                m0_r_ready_i,
    input  axi_xbar_pkg::id_t   m1_ar_id_i,
    input  axi_xbar_pkg::addr_t m1_ar_addr_i,
    input  axi_xbar_pkg::len_t  m1_ar_len_i,
    input  logic                m1_ar_valid_i,
    output logic                m1_ar_ready_o,
    output axi_xbar_pkg::id_t   m1_r_id_o,
    output axi_xbar_pkg::data_t m1_r_data_o,
    output axi_xbar_pkg::resp_t m1_r_resp_o,
    output logic                m1_r_last_o,
    output logic                m1_r_valid_o,
    input  logic                m1_r_ready_i,
    output axi_xbar_pkg::ids_t  s0_ar_id_o,
    output axi_xbar_pkg::addr_t s0_ar_addr_o,
    output axi_xbar_pkg::len_t  s0_ar_len_o,
    output logic                s0_ar_valid_o,
    input  logic                s0_ar_ready_i,
    input  axi_xbar_pkg::ids_t  s0_r_id_i,
    input  axi_xbar_pkg::data_t s0_r_data_i,
    input  axi_xbar_pkg::resp_t s0_r_resp_i,
    input  logic                s0_r_last_i,
    input  logic                s0_r_valid_i,
    output logic                s0_r_ready_o,
    output axi_xbar_pkg::ids_t  s1_ar_id_o,
    output axi_xbar_pkg::addr_t s1_ar_addr_o,
    output axi_xbar_pkg::len_t  s1_ar_len_o,
    output logic                s1_ar_valid_o,
    input  logic                s1_ar_ready_i,
    input  axi_xbar_pkg::ids_t  s1_r_id_i,
    input  axi_xbar_pkg::data_t s1_r_data_i,
    input  axi_xbar_pkg::resp_t s1_r_resp_i,
    input  logic                s1_r_last_i,
    input  logic                s1_r_valid_i,
    output logic                s1_r_ready_o
);

    import axi_xbar_pkg::*;

    // Default slave channels
    ids_t  dflt_ar_id;
    len_t  dflt_ar_len;
    logic  dflt_ar_valid;
    logic  dflt_ar_ready;
    ids_t  dflt_r_id;
    data_t dflt_r_data;
    resp_t dflt_r_resp;
    logic  dflt_r_last;
    logic  dflt_r_valid;
    logic  dflt_r_ready;

    ar_addr_decode ar_addr_decode_i (
        .clk_i(clk), .rst_i(rst),
        .m0_ar_id_i(m0_ar_id_i), .m0_ar_addr_i(m0_ar_addr_i), .m0_ar_len_i(m0_ar_len_i),
        .m0_ar_valid_i(m0_ar_valid_i), .m0_ar_ready_o(m0_ar_ready_o),
        .m1_ar_id_i(m1_ar_id_i), .m1_ar_addr_i(m1_ar_addr_i), .m1_ar_len_i(m1_ar_len_i),
        .m1_ar_valid_i(m1_ar_valid_i), .m1_ar_ready_o(m1_ar_ready_o),
        .s0_ar_id_o(s0_ar_id_o), .s0_ar_addr_o(s0_ar_addr_o), .s0_ar_len_o(s0_ar_len_o),
        .s0_ar_valid_o(s0_ar_valid_o), .s0_ar_ready_i(s0_ar_ready_i),
        .s1_ar_id_o(s1_ar_id_o), .s1_ar_addr_o(s1_ar_addr_o), .s1_ar_len_o(s1_ar_len_o),
        .s1_ar_valid_o(s1_ar_valid_o), .s1_ar_ready_i(s1_ar_ready_i),
        .dflt_ar_id_o(dflt_ar_id), .dflt_ar_addr_o(),
        .dflt_ar_len_o(dflt_ar_len), .dflt_ar_valid_o(dflt_ar_valid),
        .dflt_ar_ready_i(dflt_ar_ready)
    );

    // Every unmapped read gets the same answer whatever its address
    default_slave default_slave_i (
        .clk_i(clk), .rst_i(rst),
        .ar_id_i(dflt_ar_id), .ar_len_i(dflt_ar_len),
        .ar_valid_i(dflt_ar_valid), .ar_ready_o(dflt_ar_ready),
        .r_id_o(dflt_r_id), .r_data_o(dflt_r_data), .r_resp_o(dflt_r_resp),
        .r_last_o(dflt_r_last), .r_valid_o(dflt_r_valid), .r_ready_i(dflt_r_ready)
    );

    r_return_router r_return_router_i (
        .clk_i(clk), .rst_i(rst),
        .src0_r_id_i(s0_r_id_i), .src0_r_data_i(s0_r_data_i), .src0_r_resp_i(s0_r_resp_i),
        .src0_r_last_i(s0_r_last_i), .src0_r_valid_i(s0_r_valid_i),
        .src0_r_ready_o(s0_r_ready_o),
        .src1_r_id_i(s1_r_id_i), .src1_r_data_i(s1_r_data_i), .src1_r_resp_i(s1_r_resp_i),
        .src1_r_last_i(s1_r_last_i), .src1_r_valid_i(s1_r_valid_i),
        .src1_r_ready_o(s1_r_ready_o),
        .srcd_r_id_i(dflt_r_id), .srcd_r_data_i(dflt_r_data), .srcd_r_resp_i(dflt_r_resp),
        .srcd_r_last_i(dflt_r_last), .srcd_r_valid_i(dflt_r_valid),
        .srcd_r_ready_o(dflt_r_ready),
        .m0_r_id_o(m0_r_id_o), .m0_r_data_o(m0_r_data_o), .m0_r_resp_o(m0_r_resp_o),
        .m0_r_last_o(m0_r_last_o), .m0_r_valid_o(m0_r_valid_o), .m0_r_ready_i(m0_r_ready_i),
        .m1_r_id_o(m1_r_id_o), .m1_r_data_o(m1_r_data_o), .m1_r_resp_o(m1_r_resp_o),
        .m1_r_last_o(m1_r_last_o), .m1_r_valid_o(m1_r_valid_o), .m1_r_ready_i(m1_r_ready_i)
    );

endmodule

//--- bench/axi_read_xbar_tb.sv
`timescale 1ns/1ps

module axi_read_xbar_tb;

    import axi_xbar_pkg::*;

    localparam logic [31:0] SEED = 32'h6b7ab7c1;
    // 8 + 6 + 7 + 19 directed beats, then 2 masters x 4 bursts x 8 beats
    localparam int PLANNED_BEATS = 104;

    logic clk, rst, rst_q;
    logic [1:0] m_ar_valid, m_r_ready, s_ar_ready, s_r_last, s_r_valid;
    id_t   m_ar_id [2];
    addr_t m_ar_addr [2];
    len_t  m_ar_len [2];
    ids_t  s_r_id [2];
    data_t s_r_data [2];
    resp_t s_r_resp [2];
    wire [1:0] m_ar_ready, m_r_last, m_r_valid, s_ar_valid, s_r_ready;
    wire id_t   m_r_id [2];
    wire data_t m_r_data [2];
    wire resp_t m_r_resp [2];
    wire ids_t  s_ar_id [2];
    wire addr_t s_ar_addr [2];
    wire len_t  s_ar_len [2];

    // Expected burst per master
    id_t   exp_id [2];
    addr_t exp_addr [2];
    len_t  exp_len [2];
    logic [1:0] exp_dec, busy;
    int beat [2];

    // Slave model state
    logic [1:0] ar_hs, r_hs, sm_busy;
    addr_t cap_addr [2], sm_addr [2];
    ids_t  cap_id [2], sm_id [2];
    int cap_len [2], sm_len [2], sm_beat [2], sm_delay [2];

    logic [31:0] rng_bus;
    logic [31:0] rng_stim [2];
    int ready_threshold;
    int errors, mark, passed, failed;

    axi_read_xbar axi_read_xbar_i (
        .clk(clk), .rst(rst),
        .m0_ar_id_i(m_ar_id[0]), .m0_ar_addr_i(m_ar_addr[0]), .m0_ar_len_i(m_ar_len[0]),
        .m0_ar_valid_i(m_ar_valid[0]), .m0_ar_ready_o(m_ar_ready[0]),
        .m0_r_id_o(m_r_id[0]), .m0_r_data_o(m_r_data[0]), .m0_r_resp_o(m_r_resp[0]),
        .m0_r_last_o(m_r_last[0]), .m0_r_valid_o(m_r_valid[0]), .m0_r_ready_i(m_r_ready[0]),
        .m1_ar_id_i(m_ar_id[1]), .m1_ar_addr_i(m_ar_addr[1]), .m1_ar_len_i(m_ar_len[1]),
        .m1_ar_valid_i(m_ar_valid[1]), .m1_ar_ready_o(m_ar_ready[1]),
        .m1_r_id_o(m_r_id[1]), .m1_r_data_o(m_r_data[1]), .m1_r_resp_o(m_r_resp[1]),
        .m1_r_last_o(m_r_last[1]), .m1_r_valid_o(m_r_valid[1]), .m1_r_ready_i(m_r_ready[1]),
        .s0_ar_id_o(s_ar_id[0]), .s0_ar_addr_o(s_ar_addr[0]), .s0_ar_len_o(s_ar_len[0]),
        .s0_ar_valid_o(s_ar_valid[0]), .s0_ar_ready_i(s_ar_ready[0]),
        .s0_r_id_i(s_r_id[0]), .s0_r_data_i(s_r_data[0]), .s0_r_resp_i(s_r_resp[0]),
        .s0_r_last_i(s_r_last[0]), .s0_r_valid_i(s_r_valid[0]), .s0_r_ready_o(s_r_ready[0]),
        .s1_ar_id_o(s_ar_id[1]), .s1_ar_addr_o(s_ar_addr[1]), .s1_ar_len_o(s_ar_len[1]),
        .s1_ar_valid_o(s_ar_valid[1]), .s1_ar_ready_i(s_ar_ready[1]),
        .s1_r_id_i(s_r_id[1]), .s1_r_data_i(s_r_data[1]), .s1_r_resp_i(s_r_resp[1]),
        .s1_r_last_i(s_r_last[1]), .s1_r_valid_i(s_r_valid[1]), .s1_r_ready_o(s_r_ready[1])
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic unmapped(input addr_t a);
        return !((a >= S0_BASE && a < S0_BASE + SLAVE_SPAN) ||
                 (a >= S1_BASE && a < S1_BASE + SLAVE_SPAN));
    endfunction

    function automatic data_t expected_data(input addr_t a, input logic dec, input int b);
        return dec ? data_t'(0) : a + data_t'(4 * b);
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk or negedge rst) begin
        if (!rst)
            rst_q <= 1'b0;
        else
            rst_q <= 1'b1;
    end

    // Handshakes seen at the clock edge, acted on at the next falling edge
    always @(posedge clk) begin
        for (int m = 0; m < 2; m++) begin
            if (m_r_valid[m] && m_r_ready[m] && busy[m]) begin
                if (beat[m] == exp_len[m])
                    busy[m] <= 1'b0;
                beat[m] <= beat[m] + 1;
            end
        end
        for (int s = 0; s < 2; s++) begin
            ar_hs[s]    <= s_ar_valid[s] && s_ar_ready[s];
            r_hs[s]     <= s_r_valid[s] && s_r_ready[s];
            cap_addr[s] <= s_ar_addr[s];
            cap_id[s]   <= s_ar_id[s];
            cap_len[s]  <= s_ar_len[s];
        end
    end

    // Master r_ready and the two memory slaves
    always @(negedge clk) begin
        if (!rst) begin
            m_r_ready  = '0;
            s_ar_ready = '0;
            s_r_valid  = '0;
            sm_busy    = '0;
        end else begin
            for (int m = 0; m < 2; m++) begin
                rng_bus = xorshift32(rng_bus);
                m_r_ready[m] = (rng_bus[1:0] >= ready_threshold);
            end
            for (int s = 0; s < 2; s++) begin
                if (sm_busy[s] && r_hs[s]) begin
                    s_r_valid[s] = 1'b0;
                    if (sm_beat[s] == sm_len[s]) begin
                        sm_busy[s] = 1'b0;
                    end else begin
                        sm_beat[s] = sm_beat[s] + 1;
                        rng_bus = xorshift32(rng_bus);
                        sm_delay[s] = rng_bus[1:0];
                    end
                end
                if (!sm_busy[s] && ar_hs[s]) begin
                    sm_busy[s] = 1'b1;
                    sm_addr[s] = cap_addr[s];
                    sm_id[s]   = cap_id[s];
                    sm_len[s]  = cap_len[s];
                    sm_beat[s] = 0;
                    rng_bus = xorshift32(rng_bus);
                    sm_delay[s] = rng_bus[1:0];
                end
                s_ar_ready[s] = !sm_busy[s];
                if (sm_busy[s] && !s_r_valid[s]) begin
                    if (sm_delay[s] == 0) begin
                        s_r_id[s]    = sm_id[s];
                        s_r_data[s]  = sm_addr[s] + data_t'(4 * sm_beat[s]);
                        s_r_resp[s]  = RESP_OKAY;
                        s_r_last[s]  = (sm_beat[s] == sm_len[s]);
                        s_r_valid[s] = 1'b1;
                    end else begin
                        sm_delay[s] = sm_delay[s] - 1;
                    end
                end
            end
        end
    end

    for (genvar m = 0; m < 2; m++) begin : g_master_checks
        a_no_stray: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] |-> busy[m])
            else begin
                errors++;
                $display("Master %0d got a read beat with no read outstanding", m);
            end
        a_r_id: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] && m_r_ready[m] |-> m_r_id[m] == exp_id[m])
            else begin
                errors++;
                $display("Error m%0d_r_id_o got %h expected %h", m,
                    $sampled(m_r_id[m]), $sampled(exp_id[m]));
            end
        a_r_data: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] && m_r_ready[m] |->
                m_r_data[m] == expected_data(exp_addr[m], exp_dec[m], beat[m]))
            else begin
                errors++;
                $display("Error m%0d_r_data_o got %h expected %h", m, $sampled(m_r_data[m]),
                    expected_data($sampled(exp_addr[m]), $sampled(exp_dec[m]),
                        $sampled(beat[m])));
            end
        a_r_resp: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] && m_r_ready[m] |->
                m_r_resp[m] == (exp_dec[m] ? RESP_DECERR : RESP_OKAY))
            else begin
                errors++;
                $display("Error m%0d_r_resp_o got %h expected %h", m, $sampled(m_r_resp[m]),
                    $sampled(exp_dec[m]) ? RESP_DECERR : RESP_OKAY);
            end
        a_r_last: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] && m_r_ready[m] |-> m_r_last[m] == (beat[m] == exp_len[m]))
            else begin
                errors++;
                $display("Error m%0d_r_last_o got %h expected %h", m, $sampled(m_r_last[m]),
                    $sampled(beat[m]) == $sampled(exp_len[m]));
            end
        a_r_hold: assert property (@(posedge clk) disable iff (!rst)
            m_r_valid[m] && !m_r_ready[m] |=> m_r_valid[m] && $stable(m_r_id[m]) &&
                $stable(m_r_data[m]) && $stable(m_r_resp[m]) && $stable(m_r_last[m]))
            else begin
                errors++;
                $display("Master %0d read beat changed before it was accepted", m);
            end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_q |-> m_r_valid == '0 && s_ar_valid == '0)
        else begin
            errors++;
            $display("A valid output was high during or right after reset");
        end

    task automatic read_burst(input int m, input id_t id, input addr_t addr, input len_t len);
        @(negedge clk);
        exp_id[m]   = id;
        exp_addr[m] = addr;
        exp_len[m]  = len;
        exp_dec[m]  = unmapped(addr);
        beat[m]     = 0;
        busy[m]     = 1'b1;
        m_ar_id[m]   = id;
        m_ar_addr[m] = addr;
        m_ar_len[m]  = len;
        m_ar_valid[m] = 1'b1;
        do @(posedge clk); while (!m_ar_ready[m]);
        @(negedge clk);
        m_ar_valid[m] = 1'b0;
        wait (!busy[m]);
    endtask

    task automatic random_reads(input int m, input int count);
        addr_t base;
        for (int i = 0; i < count; i++) begin
            rng_stim[m] = xorshift32(rng_stim[m]);
            case (rng_stim[m][25:24] % 3)
                0:       base = S0_BASE;
                1:       base = S1_BASE;
                default: base = 32'h0003_0000;
            endcase
            read_burst(m, rng_stim[m][19:16], base + {rng_stim[m][15:4], 4'h0}, 4'd7);
        end
    endtask

    task automatic report_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("Test %s: ok", name);
        end else begin
            failed++;
            $display("Test %s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        repeat (PLANNED_BEATS * 200) @(posedge clk);
        $display("Timeout: reads did not finish in %0d cycles", PLANNED_BEATS * 200);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b0;
        m_ar_valid = '0;
        m_r_ready  = '0;
        s_ar_ready = '0;
        s_r_valid  = '0;
        s_r_last   = '0;
        busy = '0;
        exp_dec = '0;
        for (int i = 0; i < 2; i++) begin
            m_ar_id[i] = '0;
            m_ar_addr[i] = '0;
            m_ar_len[i] = '0;
            s_r_id[i] = '0;
            s_r_data[i] = '0;
            s_r_resp[i] = '0;
        end
        rng_bus = SEED;
        rng_stim[0] = SEED;
        rng_stim[1] = xorshift32(SEED);
        ready_threshold = 1;
        errors = 0;
        mark = 0;
        passed = 0;
        failed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        report_test("reset");
        read_burst(0, 4'h3, 32'h0000_0100, 4'd7);
        report_test("master 0 to slave 0");
        read_burst(1, 4'ha, 32'h0001_0040, 4'd5);
        report_test("master 1 to slave 1");
        read_burst(0, 4'h5, 32'h0004_0000, 4'd3);
        read_burst(1, 4'h6, 32'h8000_0010, 4'd2);
        report_test("unmapped reads");
        fork
            read_burst(0, 4'h1, 32'h0000_0200, 4'd4);
            read_burst(1, 4'h1, 32'h0000_0300, 4'd6);
        join
        fork
            read_burst(0, 4'h2, 32'h0001_0800, 4'd3);
            read_burst(1, 4'h9, 32'h0000_0400, 4'd2);
        join
        report_test("both masters at once");
        // Heavier back-pressure for the random run
        ready_threshold = 2;
        fork
            random_reads(0, 4);
            random_reads(1, 4);
        join
        ready_threshold = 1;
        report_test("random back-pressure");
        repeat (5) @(negedge clk);
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
            passed + failed, passed, failed, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- axi_read_xbar.f
design/axi_xbar_pkg.sv
design/ar_addr_decode.sv
design/default_slave.sv
design/r_return_router.sv
design/axi_read_xbar.sv
bench/axi_read_xbar_tb.sv

//--- Bender.yml
package:
  name: axi_read_xbar

sources:
  - files:
      - design/axi_xbar_pkg.sv
      - design/ar_addr_decode.sv
      - design/default_slave.sv
      - design/r_return_router.sv
      - design/axi_read_xbar.sv
  - target: test
    files:
      - bench/axi_read_xbar_tb.sv
